// File: hw/rs_config_pkg.sv
package rs_config_pkg;

	localparam int data_width = 64;     // Operand and result width
	localparam int tag_width = 5;       // Destination and source tags, 32 of them
	localparam int rob_index_width = 5; // Reorder buffer slot index

	// Pad bits above the tag field of a waiting operand
	localparam int ref_pad_width = data_width - tag_width;

	// Operand still waiting on a producer
	typedef struct packed {
		logic [ref_pad_width-1:0] pad; // Ignored while waiting
		logic [tag_width-1:0]     tag; // Producer tag to match on the CDB
	} operand_ref_t;

	// One operand word, read through the valid bit that travels beside it
	typedef union packed {
		logic [data_width-1:0] value;   // Valid bit set
		operand_ref_t          waiting; // Valid bit clear
	} operand_t;

endpackage

// File: hw/alu_op_pkg.sv
package alu_op_pkg;

	localparam int alu_op_width = 3; // Eight operations

	// Integer operations of the single functional unit
	typedef enum logic [alu_op_width-1:0] {
		alu_add  = 3'd0, // a + b
		alu_sub  = 3'd1, // a - b
		alu_and  = 3'd2, // Bitwise and
		alu_or   = 3'd3, // Bitwise or
		alu_xor  = 3'd4, // Bitwise xor
		alu_sll  = 3'd5, // Logical left by b[5:0]
		alu_srl  = 3'd6, // Logical right by b[5:0]
		alu_sltu = 3'd7  // 1 when a < b unsigned, else 0
	} alu_op_t;

endpackage

// File: hw/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
	parameter int rs_size = 8
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        flush,
	input  logic                                        dispatch_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         dest_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   rob_index,
	input  alu_op_pkg::alu_op_t                         op,
	input  rs_config_pkg::operand_t                     operand_a,
	input  logic                                        operand_a_valid,
	input  rs_config_pkg::operand_t                     operand_b,
	input  logic                                        operand_b_valid,
	input  logic                                        cdb_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         cdb_tag,
	input  logic [rs_config_pkg::data_width-1:0]        cdb_value,
	input  logic                                        issue_allowed,
	output logic                                        rs_full,
	output logic                                        issue_valid,
	output alu_op_pkg::alu_op_t                         issue_op,
	output logic [rs_config_pkg::data_width-1:0]        issue_a,
	output logic [rs_config_pkg::data_width-1:0]        issue_b,
	output logic [rs_config_pkg::tag_width-1:0]         issue_tag,
	output logic [rs_config_pkg::rob_index_width-1:0]   issue_rob_index
);

	localparam int idx_width = $clog2(rs_size);

	logic [rs_size-1:0]                        occupied;  // Entry holds a live instruction
	logic [rs_size-1:0]                        opa_valid; // Operand A read as value
	logic [rs_size-1:0]                        opb_valid; // Operand B read as value
	rs_config_pkg::operand_t                   opa [rs_size];
	rs_config_pkg::operand_t                   opb [rs_size];
	logic [rs_config_pkg::tag_width-1:0]       dest [rs_size];
	logic [rs_config_pkg::rob_index_width-1:0] rob [rs_size];
	alu_op_pkg::alu_op_t                       op_q [rs_size];

	logic [rs_size-1:0]   ready;     // Occupied with both operands present
	logic [rs_size-1:0]   capture_a; // Waiting A matches the CDB
	logic [rs_size-1:0]   capture_b; // Waiting B matches the CDB
	logic [idx_width-1:0] free_idx;  // Lowest free entry
	logic [idx_width-1:0] issue_idx; // Lowest ready entry
	logic                 dispatch_write;
	logic                 bypass_a;  // Producer on the CDB during dispatch
	logic                 bypass_b;
	rs_config_pkg::operand_t dispatch_a; // Operand after bypass
	rs_config_pkg::operand_t dispatch_b;
	logic                 tag_clash; // Two live entries with one dest tag

	assign rs_full = &occupied;
	assign dispatch_write = dispatch_valid && !rs_full;
	assign ready = occupied & opa_valid & opb_valid;
	assign issue_valid = |ready && issue_allowed;

	// Same-cycle bypass reads the incoming word as a tag
	assign bypass_a = cdb_valid && !operand_a_valid && operand_a.waiting.tag == cdb_tag;
	assign bypass_b = cdb_valid && !operand_b_valid && operand_b.waiting.tag == cdb_tag;

	always_comb
	begin
		dispatch_a = operand_a;
		dispatch_b = operand_b;
		if (bypass_a)
			dispatch_a.value = cdb_value; // Now a value
		if (bypass_b)
			dispatch_b.value = cdb_value;
	end

	// Wake-up compare per entry
	always_comb
	begin
		for (int i = 0; i < rs_size; i++)
		begin
			capture_a[i] = cdb_valid && occupied[i] && !opa_valid[i]
				&& opa[i].waiting.tag == cdb_tag;
			capture_b[i] = cdb_valid && occupied[i] && !opb_valid[i]
				&& opb[i].waiting.tag == cdb_tag;
		end
	end

	// Downward priority searches leave the lowest index
	always_comb
	begin
		free_idx = '0;
		issue_idx = '0;
		for (int i = rs_size - 1; i >= 0; i--)
		begin
			if (!occupied[i])
				free_idx = idx_width'(i);
			if (ready[i])
				issue_idx = idx_width'(i);
		end
	end

	assign issue_op = op_q[issue_idx];
	assign issue_a = opa[issue_idx].value;
	assign issue_b = opb[issue_idx].value;
	assign issue_tag = dest[issue_idx];
	assign issue_rob_index = rob[issue_idx];

	// Occupancy with the issued entry freed at the issue edge
	always_ff @(posedge clock)
	begin
		if (reset || flush)
			occupied <= '0;
		else
		begin
			for (int i = 0; i < rs_size; i++)
			begin
				if (dispatch_write && free_idx == idx_width'(i))
					occupied[i] <= 1'b1;
				else if (issue_valid && issue_idx == idx_width'(i))
					occupied[i] <= 1'b0;
			end
		end
	end

	// Entry payload and operand capture
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rs_size; i++)
		begin
			if (dispatch_write && free_idx == idx_width'(i))
			begin
				opa[i] <= dispatch_a;
				opb[i] <= dispatch_b;
				opa_valid[i] <= operand_a_valid || bypass_a;
				opb_valid[i] <= operand_b_valid || bypass_b;
				dest[i] <= dest_tag;
				rob[i] <= rob_index;
				op_q[i] <= op;
			end
			else
			begin
				if (capture_a[i])
				begin
					opa[i].value <= cdb_value; // Tag field overwritten
					opa_valid[i] <= 1'b1;
				end
				if (capture_b[i])
				begin
					opb[i].value <= cdb_value;
					opb_valid[i] <= 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		tag_clash = 1'b0;
		for (int i = 0; i < rs_size; i++)
			for (int j = i + 1; j < rs_size; j++)
				if (occupied[i] && occupied[j] && dest[i] == dest[j])
					tag_clash = 1'b1;
	end

	// Rename stage honours the full level
	a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
		dispatch_valid |-> !rs_full)
		else $error("dispatch while station full");

	// Issued entry carries known operands and is gone one cycle later
	a_issue_ready: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> !$isunknown({issue_a, issue_b, issue_tag})
			##1 !occupied[$past(issue_idx)])
		else $error("issue with unknown operands or entry not freed");

	// A tag names one in-flight result
	a_unique_dest: assert property (@(posedge clock) disable iff (reset)
		!tag_clash)
		else $error("two live entries share a destination tag");

endmodule

// File: hw/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        flush,
	input  logic                                        issue_valid,
	input  alu_op_pkg::alu_op_t                         issue_op,
	input  logic [rs_config_pkg::data_width-1:0]        issue_a,
	input  logic [rs_config_pkg::data_width-1:0]        issue_b,
	input  logic [rs_config_pkg::tag_width-1:0]         issue_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   issue_rob_index,
	output logic                                        alu_valid,
	output logic [rs_config_pkg::tag_width-1:0]         alu_tag,
	output logic [rs_config_pkg::rob_index_width-1:0]   alu_rob_index,
	output logic [rs_config_pkg::data_width-1:0]        alu_value
);

	localparam int shamt_width = $clog2(rs_config_pkg::data_width); // 6 for 64 bits

	logic                                      s1_valid;
	alu_op_pkg::alu_op_t                       s1_op;
	logic [rs_config_pkg::data_width-1:0]      s1_a;
	logic [rs_config_pkg::data_width-1:0]      s1_b;
	logic [shamt_width-1:0]                    s1_shamt; // Low bits of b
	logic                                      s1_ltu;   // Unsigned a < b
	logic [rs_config_pkg::tag_width-1:0]       s1_tag;
	logic [rs_config_pkg::rob_index_width-1:0] s1_rob;
	logic [rs_config_pkg::data_width-1:0]      result;   // Stage two select

	// Stage one
	always_ff @(posedge clock)
	begin
		if (reset || flush)
			s1_valid <= 1'b0;
		else
			s1_valid <= issue_valid;
	end

	always_ff @(posedge clock)
	begin
		s1_op <= issue_op;
		s1_a <= issue_a;
		s1_b <= issue_b;
		s1_shamt <= issue_b[shamt_width-1:0];
		s1_ltu <= issue_a < issue_b; // Compare ahead of the select
		s1_tag <= issue_tag;
		s1_rob <= issue_rob_index;
	end

	always_comb
	begin
		case (s1_op)
			alu_op_pkg::alu_add:  result = s1_a + s1_b;
			alu_op_pkg::alu_sub:  result = s1_a - s1_b;
			alu_op_pkg::alu_and:  result = s1_a & s1_b;
			alu_op_pkg::alu_or:   result = s1_a | s1_b;
			alu_op_pkg::alu_xor:  result = s1_a ^ s1_b;
			alu_op_pkg::alu_sll:  result = s1_a << s1_shamt;
			alu_op_pkg::alu_srl:  result = s1_a >> s1_shamt;
			alu_op_pkg::alu_sltu: result = rs_config_pkg::data_width'(s1_ltu);
			default:              result = '0;
		endcase
	end

	// Stage two
	always_ff @(posedge clock)
	begin
		if (reset || flush)
			alu_valid <= 1'b0;
		else
			alu_valid <= s1_valid;
	end

	always_ff @(posedge clock)
	begin
		alu_value <= result;
		alu_tag <= s1_tag; // Tag rides with the result
		alu_rob_index <= s1_rob;
	end

endmodule

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
	parameter int result_queue_depth = 4
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        flush,
	input  logic                                        issue_valid,
	input  logic                                        alu_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         alu_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   alu_rob_index,
	input  logic [rs_config_pkg::data_width-1:0]        alu_value,
	input  logic                                        ext_wb_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         ext_wb_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   ext_wb_rob_index,
	input  logic [rs_config_pkg::data_width-1:0]        ext_wb_value,
	output logic                                        issue_allowed,
	output logic                                        cdb_valid,
	output logic [rs_config_pkg::tag_width-1:0]         cdb_tag,
	output logic [rs_config_pkg::rob_index_width-1:0]   cdb_rob_index,
	output logic [rs_config_pkg::data_width-1:0]        cdb_value
);

	localparam int ptr_width = $clog2(result_queue_depth);
	localparam int count_width = $clog2(result_queue_depth + 1);

	logic [rs_config_pkg::tag_width-1:0]       q_tag [result_queue_depth];
	logic [rs_config_pkg::rob_index_width-1:0] q_rob [result_queue_depth];
	logic [rs_config_pkg::data_width-1:0]      q_value [result_queue_depth];
	logic [ptr_width-1:0]   head;
	logic [ptr_width-1:0]   tail;
	logic [count_width-1:0] q_count; // Results waiting
	logic [count_width-1:0] credit;  // ALU ops issued, not yet on the CDB
	logic push;       // ALU result parks in the queue
	logic pop;        // Queue head goes to the CDB
	logic alu_direct; // Empty queue, ALU result goes straight out
	logic alu_sent;   // Some ALU result leaves this cycle

	// Circular advance, depth need not be a power of two
	function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
		return (ptr == ptr_width'(result_queue_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign pop = !ext_wb_valid && q_count != '0;
	assign alu_direct = !ext_wb_valid && q_count == '0 && alu_valid;
	assign push = alu_valid && !alu_direct;
	assign alu_sent = pop || alu_direct;
	assign issue_allowed = credit < count_width'(result_queue_depth);

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			head <= '0;
			tail <= '0;
			q_count <= '0;
			credit <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			if (push)
				tail <= next_ptr(tail);
			if (pop)
				head <= next_ptr(head);
			if (push && !pop)
				q_count <= q_count + 1'b1;
			else if (pop && !push)
				q_count <= q_count - 1'b1;
			if (issue_valid && !alu_sent)
				credit <= credit + 1'b1;
			else if (alu_sent && !issue_valid)
				credit <= credit - 1'b1;
			cdb_valid <= ext_wb_valid || alu_sent; // Outside writeback never waits
		end
	end

	// Queue slots and CDB payload
	always_ff @(posedge clock)
	begin
		if (push)
		begin
			q_tag[tail] <= alu_tag;
			q_rob[tail] <= alu_rob_index;
			q_value[tail] <= alu_value;
		end
		if (ext_wb_valid)
		begin
			cdb_tag <= ext_wb_tag;
			cdb_rob_index <= ext_wb_rob_index;
			cdb_value <= ext_wb_value;
		end
		else if (pop)
		begin
			cdb_tag <= q_tag[head]; // Oldest waiting result first
			cdb_rob_index <= q_rob[head];
			cdb_value <= q_value[head];
		end
		else
		begin
			cdb_tag <= alu_tag;
			cdb_rob_index <= alu_rob_index;
			cdb_value <= alu_value;
		end
	end

	// Station credit keeps the queue from overflowing
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		push |-> q_count < count_width'(result_queue_depth))
		else $error("ALU result pushed into full queue");

	a_credit_bound: assert property (@(posedge clock) disable iff (reset)
		credit <= count_width'(result_queue_depth))
		else $error("issue credit above queue depth");

endmodule

// File: hw/tomasulo_slice.sv
`timescale 1ns/1ps

module tomasulo_slice #(
	parameter int rs_size = 8,
	parameter int result_queue_depth = 4
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        flush,
	input  logic                                        dispatch_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         dest_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   rob_index,
	input  alu_op_pkg::alu_op_t                         op,
	input  rs_config_pkg::operand_t                     operand_a,
	input  logic                                        operand_a_valid,
	input  rs_config_pkg::operand_t                     operand_b,
	input  logic                                        operand_b_valid,
	input  logic                                        ext_wb_valid,
	input  logic [rs_config_pkg::tag_width-1:0]         ext_wb_tag,
	input  logic [rs_config_pkg::rob_index_width-1:0]   ext_wb_rob_index,
	input  logic [rs_config_pkg::data_width-1:0]        ext_wb_value,
	output logic                                        rs_full,
	output logic                                        cdb_valid,
	output logic [rs_config_pkg::tag_width-1:0]         cdb_tag,
	output logic [rs_config_pkg::rob_index_width-1:0]   cdb_rob_index,
	output logic [rs_config_pkg::data_width-1:0]        cdb_value
);

	logic                                      issue_allowed; // Credit left
	logic                                      issue_valid;
	alu_op_pkg::alu_op_t                       issue_op;
	logic [rs_config_pkg::data_width-1:0]      issue_a;
	logic [rs_config_pkg::data_width-1:0]      issue_b;
	logic [rs_config_pkg::tag_width-1:0]       issue_tag;
	logic [rs_config_pkg::rob_index_width-1:0] issue_rob_index;
	logic                                      alu_valid;
	logic [rs_config_pkg::tag_width-1:0]       alu_tag;
	logic [rs_config_pkg::rob_index_width-1:0] alu_rob_index;
	logic [rs_config_pkg::data_width-1:0]      alu_value;

	reservation_station #(
		.rs_size(rs_size)
	) u_reservation_station (
		.clock, .reset, .flush,
		.dispatch_valid, .dest_tag, .rob_index, .op,
		.operand_a, .operand_a_valid, .operand_b, .operand_b_valid,
		.cdb_valid, .cdb_tag, .cdb_value, // Wake-up from the registered CDB
		.issue_allowed, .rs_full,
		.issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag, .issue_rob_index
	);

	exec_alu u_exec_alu (
		.clock, .reset, .flush,
		.issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag, .issue_rob_index,
		.alu_valid, .alu_tag, .alu_rob_index, .alu_value
	);

	cdb_arbiter #(
		.result_queue_depth(result_queue_depth)
	) u_cdb_arbiter (
		.clock, .reset, .flush,
		.issue_valid, // Credit taken per issue
		.alu_valid, .alu_tag, .alu_rob_index, .alu_value,
		.ext_wb_valid, .ext_wb_tag, .ext_wb_rob_index, .ext_wb_value,
		.issue_allowed,
		.cdb_valid, .cdb_tag, .cdb_rob_index, .cdb_value
	);

endmodule

// File: verification/tb_tomasulo_slice.sv
`timescale 1ns/1ps

module tb_tomasulo_slice;

	localparam int clock_period = 100;
	localparam int station_entries = 8; // Default rs_size of the slice
	localparam int random_dispatches = 150; // Per random phase
	localparam int planned_dispatches = 2 * random_dispatches + station_entries;
	localparam int num_tags = 2 ** rs_config_pkg::tag_width;

	logic clock;
	logic reset;
	logic flush;
	logic dispatch_valid;
	logic [rs_config_pkg::tag_width-1:0] dest_tag;
	logic [rs_config_pkg::rob_index_width-1:0] rob_index;
	alu_op_pkg::alu_op_t op;
	rs_config_pkg::operand_t operand_a;
	logic operand_a_valid;
	rs_config_pkg::operand_t operand_b;
	logic operand_b_valid;
	logic ext_wb_valid;
	logic [rs_config_pkg::tag_width-1:0] ext_wb_tag;
	logic [rs_config_pkg::rob_index_width-1:0] ext_wb_rob_index;
	logic [rs_config_pkg::data_width-1:0] ext_wb_value;
	logic rs_full;
	logic cdb_valid;
	logic [rs_config_pkg::tag_width-1:0] cdb_tag;
	logic [rs_config_pkg::rob_index_width-1:0] cdb_rob_index;
	logic [rs_config_pkg::data_width-1:0] cdb_value;

	bit busy [num_tags];     // Result still owed on the CDB
	bit is_ext [num_tags];   // Produced by the outside port
	bit ext_sent [num_tags]; // Writeback already driven
	int ext_due [num_tags];  // Earliest cycle for the writeback
	bit seen [num_tags];     // A broadcast value exists
	bit a_rdy [num_tags];
	bit b_rdy [num_tags];
	alu_op_pkg::alu_op_t op_of [num_tags];
	logic [rs_config_pkg::tag_width-1:0] a_src [num_tags]; // Producer tags
	logic [rs_config_pkg::tag_width-1:0] b_src [num_tags];
	logic [rs_config_pkg::rob_index_width-1:0] rob_of [num_tags];
	logic [rs_config_pkg::data_width-1:0] a_val [num_tags];
	logic [rs_config_pkg::data_width-1:0] b_val [num_tags];
	logic [rs_config_pkg::data_width-1:0] ext_val [num_tags];
	logic [rs_config_pkg::data_width-1:0] resolved [num_tags]; // Last broadcast value

	logic [31:0] lfsr;
	int cycle;
	int dispatched;      // Real dispatches in this phase
	int hold_tag;        // Forced wait source, -1 when unused
	int bypass_tag;
	bit bypass_pending;  // Dependent goes out next cycle
	bit last_dispatch;
	bit full_seen;       // rs_full at the last negedge
	bit quiet;           // No broadcast allowed
	bit allow_ext_decl;
	bit wb_expect;       // Writeback due on the CDB this cycle
	logic [rs_config_pkg::tag_width-1:0] wb_tag;
	logic [rs_config_pkg::rob_index_width-1:0] wb_rob;
	logic [rs_config_pkg::data_width-1:0] wb_value;

	tomasulo_slice u_tomasulo_slice (.*);

	initial
	begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// Galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
	endfunction

	function automatic logic [63:0] take_bits(input int count);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr_step(lfsr); // One step per bit
			bits = {bits[62:0], lfsr[0]};
		end
		return bits;
	endfunction

	// Random start, first tag in the wanted state
	function automatic int find_tag(input bit want_busy);
		int start;
		start = int'(take_bits(rs_config_pkg::tag_width));
		for (int i = 0; i < num_tags; i++)
			if (busy[(start + i) % num_tags] == want_busy)
				return (start + i) % num_tags;
		return -1;
	endfunction

	function automatic logic [rs_config_pkg::data_width-1:0] expected_result(
		input alu_op_pkg::alu_op_t kind, input logic [rs_config_pkg::data_width-1:0] a,
		input logic [rs_config_pkg::data_width-1:0] b);
		case (kind)
			alu_op_pkg::alu_add:  return a + b;
			alu_op_pkg::alu_sub:  return a - b;
			alu_op_pkg::alu_and:  return a & b;
			alu_op_pkg::alu_or:   return a | b;
			alu_op_pkg::alu_xor:  return a ^ b;
			alu_op_pkg::alu_sll:  return a << b[5:0]; // Low six bits only
			alu_op_pkg::alu_srl:  return a >> b[5:0];
			alu_op_pkg::alu_sltu: return (a < b) ? 64'd1 : 64'd0;
			default:              return 'x;
		endcase
	endfunction

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_value(input string name,
		input logic [rs_config_pkg::data_width-1:0] actual,
		input logic [rs_config_pkg::data_width-1:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic compare_tag(input string name,
		input logic [rs_config_pkg::tag_width-1:0] actual,
		input logic [rs_config_pkg::tag_width-1:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic compare_rob(input string name,
		input logic [rs_config_pkg::rob_index_width-1:0] actual,
		input logic [rs_config_pkg::rob_index_width-1:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic compare_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
			stop_run();
		end
	endtask

	// Waiting tag through the union, or a known value
	task automatic pick_operand(input int forced, output rs_config_pkg::operand_t word,
		output logic word_valid, output logic [rs_config_pkg::tag_width-1:0] src);
		int t;
		t = forced;
		if (t < 0 && take_bits(1))
			t = find_tag(1'b1); // In-flight producer, if any
		src = '0;
		if (t >= 0)
		begin
			word.waiting.tag = rs_config_pkg::tag_width'(t);
			word.waiting.pad = rs_config_pkg::ref_pad_width'(
				take_bits(rs_config_pkg::ref_pad_width)); // Junk the station must ignore
			word_valid = 1'b0;
			src = rs_config_pkg::tag_width'(t);
		end
		else
		begin
			t = int'(take_bits(rs_config_pkg::tag_width));
			if (seen[t] && take_bits(1))
				word.value = resolved[t]; // Forwarded from an old broadcast
			else
				word.value = take_bits(rs_config_pkg::data_width);
			word_valid = 1'b1;
		end
	endtask

	task automatic dispatch_one(input int wait_tag);
		int t;
		rs_config_pkg::operand_t word_a;
		rs_config_pkg::operand_t word_b;
		logic valid_a;
		logic valid_b;
		t = find_tag(1'b0);
		if (t < 0)
			return; // All tags in flight
		pick_operand(wait_tag, word_a, valid_a, a_src[t]);
		pick_operand(-1, word_b, valid_b, b_src[t]);
		busy[t] = 1'b1;
		is_ext[t] = 1'b0;
		op_of[t] = alu_op_pkg::alu_op_t'(alu_op_pkg::alu_op_width'(take_bits(3)));
		rob_of[t] = rs_config_pkg::rob_index_width'(take_bits(rs_config_pkg::rob_index_width));
		a_rdy[t] = valid_a;
		b_rdy[t] = valid_b;
		a_val[t] = word_a.value;
		b_val[t] = word_b.value;
		dispatch_valid <= 1'b1;
		dest_tag <= rs_config_pkg::tag_width'(t);
		rob_index <= rob_of[t];
		op <= op_of[t];
		operand_a <= word_a;
		operand_a_valid <= valid_a;
		operand_b <= word_b;
		operand_b_valid <= valid_b;
		last_dispatch = 1'b1;
		dispatched++;
	endtask

	// Tag owned by the outside port, written back later
	task automatic declare_ext(input int delay, output int t);
		t = find_tag(1'b0);
		if (t < 0)
			return;
		busy[t] = 1'b1;
		is_ext[t] = 1'b1;
		ext_sent[t] = 1'b0;
		ext_due[t] = cycle + delay;
		ext_val[t] = take_bits(rs_config_pkg::data_width);
		rob_of[t] = rs_config_pkg::rob_index_width'(take_bits(rs_config_pkg::rob_index_width));
	endtask

	task automatic clear_model();
		for (int i = 0; i < num_tags; i++)
		begin
			busy[i] = 1'b0;
			ext_sent[i] = 1'b0;
		end
		wb_expect = 1'b0;
		bypass_pending = 1'b0;
		last_dispatch = 1'b0;
	endtask

	function automatic bit any_busy();
		for (int i = 0; i < num_tags; i++)
			if (busy[i])
				return 1'b1;
		return 1'b0;
	endfunction

	// Sampled mid-cycle, CDB and inputs are stable
	task automatic observe();
		logic [rs_config_pkg::tag_width-1:0] t;
		full_seen = rs_full;
		if (quiet)
			compare_flag("cdb_valid", cdb_valid, 1'b0);
		if (wb_expect)
		begin
			compare_flag("cdb_valid", cdb_valid, 1'b1); // Writeback one cycle later
			compare_tag("cdb_tag", cdb_tag, wb_tag);
			compare_value("cdb_value", cdb_value, wb_value);
			compare_rob("cdb_rob_index", cdb_rob_index, wb_rob);
		end
		wb_expect = ext_wb_valid;
		wb_tag = ext_wb_tag;
		wb_rob = ext_wb_rob_index;
		wb_value = ext_wb_value;
		if (cdb_valid)
		begin
			t = cdb_tag;
			if (!busy[t])
			begin
				$display("tag %0d broadcast twice or never dispatched", t);
				stop_run();
			end
			compare_rob("cdb_rob_index", cdb_rob_index, rob_of[t]);
			if (is_ext[t])
				compare_value("cdb_value", cdb_value, ext_val[t]);
			else
			begin
				if (!(a_rdy[t] && b_rdy[t]))
				begin
					$display("tag %0d broadcast before its source tags", t);
					stop_run();
				end
				compare_value("cdb_value", cdb_value, expected_result(op_of[t], a_val[t], b_val[t]));
			end
			busy[t] = 1'b0;
			seen[t] = 1'b1;
			resolved[t] = cdb_value;
			for (int i = 0; i < num_tags; i++)
			begin
				if (busy[i] && !is_ext[i] && !a_rdy[i] && a_src[i] == t)
				begin
					a_val[i] = cdb_value; // Wake-up, bypass included
					a_rdy[i] = 1'b1;
				end
				if (busy[i] && !is_ext[i] && !b_rdy[i] && b_src[i] == t)
				begin
					b_val[i] = cdb_value;
					b_rdy[i] = 1'b1;
				end
			end
		end
	endtask

	task automatic step(input bit may_dispatch);
		int e;
		int unused;
		bit prev_dispatch;
		bit bypass_now;
		@(posedge clock);
		cycle++;
		prev_dispatch = last_dispatch;
		bypass_now = bypass_pending;
		last_dispatch = 1'b0;
		bypass_pending = 1'b0;
		dispatch_valid <= 1'b0;
		ext_wb_valid <= 1'b0;
		e = -1;
		for (int i = 0; i < num_tags; i++)
			if (e < 0 && busy[i] && is_ext[i] && !ext_sent[i] && ext_due[i] <= cycle)
				e = i;
		if (e >= 0)
		begin
			ext_sent[e] = 1'b1;
			ext_wb_valid <= 1'b1;
			ext_wb_tag <= rs_config_pkg::tag_width'(e);
			ext_wb_rob_index <= rob_of[e];
			ext_wb_value <= ext_val[e];
			bypass_tag = e; // Its dependent meets it on the CDB
			bypass_pending = 1'b1;
		end
		else if (may_dispatch && !prev_dispatch && !full_seen) // Full level is one cycle late
		begin
			if (bypass_now)
				dispatch_one(bypass_tag);
			else if (hold_tag >= 0)
				dispatch_one(hold_tag);
			else if (allow_ext_decl && take_bits(2) == 0)
				declare_ext(int'(take_bits(4)) + 1, unused);
			else
				dispatch_one(-1);
		end
		@(negedge clock);
		observe();
	endtask

	task automatic flush_slice();
		@(posedge clock);
		flush <= 1'b1;
		dispatch_valid <= 1'b0;
		ext_wb_valid <= 1'b0;
		@(negedge clock);
		observe(); // Last broadcast ahead of the flush
		@(posedge clock);
		flush <= 1'b0;
		clear_model();
		quiet = 1'b1;
		@(negedge clock);
		compare_flag("rs_full", rs_full, 1'b0);
		observe();
		repeat (4) step(1'b0);
		quiet = 1'b0;
	endtask

	initial
	begin
		#(planned_dispatches * 40 * clock_period);
		$display("timeout: run did not finish within its cycle budget");
		stop_run();
	end

	initial
	begin
		reset = 1'b1;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dest_tag = '0;
		rob_index = '0;
		op = alu_op_pkg::alu_add;
		operand_a = '0;
		operand_a_valid = 1'b0;
		operand_b = '0;
		operand_b_valid = 1'b0;
		ext_wb_valid = 1'b0;
		ext_wb_tag = '0;
		ext_wb_rob_index = '0;
		ext_wb_value = '0;
		lfsr = 32'h7ca8763c;
		cycle = 0;
		hold_tag = -1;
		quiet = 1'b0;
		allow_ext_decl = 1'b1;
		clear_model();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compare_flag("rs_full", rs_full, 1'b0);
		compare_flag("cdb_valid", cdb_valid, 1'b0);

		dispatched = 0; // Random traffic, flushed with work in flight
		while (dispatched < random_dispatches)
			step(1'b1);
		flush_slice();

		allow_ext_decl = 1'b0; // Fill the station behind one late writeback
		declare_ext(1000000, hold_tag);
		dispatched = 0;
		while (dispatched < station_entries)
			step(1'b1);
		step(1'b0);
		compare_flag("rs_full", rs_full, 1'b1);
		ext_due[hold_tag] = cycle + 1;
		hold_tag = -1;
		while (any_busy())
			step(1'b0);
		compare_flag("rs_full", rs_full, 1'b0);

		allow_ext_decl = 1'b1;
		dispatched = 0;
		while (dispatched < random_dispatches)
			step(1'b1);
		while (any_busy())
			step(1'b0); // Drain, the watchdog bounds it
		$display("Regression passed");
		$finish;
	end

endmodule

// File: src.f
hw/rs_config_pkg.sv
hw/alu_op_pkg.sv
hw/reservation_station.sv
hw/exec_alu.sv
hw/cdb_arbiter.sv
hw/tomasulo_slice.sv
verification/tb_tomasulo_slice.sv
